//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fsmc_ahb_slave_tb
FILELIST  = fsmc_ahb_slave.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN     = obj_dir/V$(TOP)
LOG     = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- ahb/ahb_bus_port.sv
`timescale 1ns/1ps

module ahb_bus_port import fsmc_pkg::*; #(
  parameter logic [19:0] CTRL_PAGE    = 20'hA_0000,
  parameter logic [3:0]  BANK1_NIBBLE = 4'h6
) (
  input  logic          hclk,
  input  logic          hresetn,
  input  logic          hsel,
  input  logic          hwrite,
  input  logic          hready,
  input  htrans_e       htrans,
  input  ahb_addr_t     haddr,
  input  ahb_data_t     ctrl_rdata,
  input  ahb_data_t     mem_rdata,
  input  logic          hreadyout_bank,
  output bank_sel_t     bank_hit,
  output bank_sel_t     fsmc_bank_sel,
  output logic          reg_wr,
  output reg_word_idx_t wr_idx,
  output reg_word_idx_t rd_idx,
  output ahb_data_t     hrdata,
  output logic          hreadyout
);

  logic    ctrl_hit;
  logic    ctrl_sel;
  logic    bank_any;
  logic    hwrite_r;
  htrans_e htrans_r;

  // ------------------------------------------------------------
  // Address phase decode
  // ------------------------------------------------------------
  assign ctrl_hit = hsel && (haddr[31:12] == CTRL_PAGE);

  // Banks 2 to 4 follow bank 1 in consecutive nibbles
  for (genvar i = 0; i < 4; i++) begin : g_bank_dec
    assign bank_hit[i] = hsel && (haddr[31:28] == 4'(BANK1_NIBBLE + i));
  end

  // Data phase owner, held while the bus is stalled
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      ctrl_sel      <= 1'b0;
      fsmc_bank_sel <= '0;
    end else if (hready) begin
      ctrl_sel      <= ctrl_hit;
      fsmc_bank_sel <= bank_hit;
    end
  end

  // Transfer capture, cleared when no transfer is accepted
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      hwrite_r <= 1'b0;
      htrans_r <= HTRANS_IDLE;
      wr_idx   <= '0;
    end else if (hsel && hready) begin
      hwrite_r <= hwrite;
      htrans_r <= htrans;
      wr_idx   <= haddr[9:2];
    end else begin
      hwrite_r <= 1'b0;
      htrans_r <= HTRANS_IDLE;
      wr_idx   <= '0;
    end
  end

  assign reg_wr = ctrl_sel && hwrite_r &&
                  (htrans_r == HTRANS_NONSEQ || htrans_r == HTRANS_SEQ);

  // Read index for the register mux
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      rd_idx <= '0;
    else if (hready && hsel)
      rd_idx <= haddr[9:2];
  end

  // ------------------------------------------------------------
  // Data phase response
  // ------------------------------------------------------------
  assign bank_any = |fsmc_bank_sel;

  assign hrdata    = ctrl_sel ? ctrl_rdata :
                     bank_any ? mem_rdata  : '0;
  assign hreadyout = ctrl_sel ? 1'b1 :
                     bank_any ? hreadyout_bank : 1'b1;   // Control page is zero-wait

endmodule

//--- bench/fsmc_ahb_slave_checker.sv
`timescale 1ns/1ps

module fsmc_ahb_slave_checker import fsmc_pkg::*; (
  input logic       hclk,
  input logic       hresetn,
  input logic       hready,
  input logic       ahb_access,
  input logic       tx_byte,
  input logic       tx_word,
  input bank_sel_t  fsmc_bank_sel,
  input logic [1:0] hresp
);

  int fail_count = 0;   // Failed assertion count

  // ------------------------------------------------------------
  // Bus and memory side properties
  // ------------------------------------------------------------
  a_bank_onehot: assert property (@(posedge hclk) disable iff (!hresetn)
    $onehot0(fsmc_bank_sel))
    else begin
      $error("fsmc_bank_sel selects more than one bank");
      fail_count++;
    end

  a_resp_okay: assert property (@(posedge hclk) hresp == hresp_okay)
    else begin
      $error("hresp is not OKAY");
      fail_count++;
    end

  a_access_ready: assert property (@(posedge hclk) disable iff (!hresetn)
    ahb_access |-> hready)
    else begin
      $error("ahb_access without hready");
      fail_count++;
    end

  a_size_excl: assert property (@(posedge hclk) disable iff (!hresetn)
    !(tx_byte && tx_word))
    else begin
      $error("tx_byte and tx_word both set");
      fail_count++;
    end

endmodule

bind fsmc_ahb_slave fsmc_ahb_slave_checker u_checker (
  .hclk, .hresetn, .hready, .ahb_access, .tx_byte, .tx_word, .fsmc_bank_sel, .hresp
);

//--- bench/fsmc_ahb_slave_tb.sv
`timescale 1ns/1ps

module fsmc_ahb_slave_tb import fsmc_pkg::*; ();

  localparam logic [19:0] CTRL_PAGE      = 20'hA_0000;
  localparam logic [3:0]  BANK1_NIBBLE   = 4'h6;
  localparam logic [31:0] LFSR_SEED      = 32'he01a;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
  localparam int          NUM_XFERS      = 400;
  localparam int          TIMEOUT_CYCLES = NUM_XFERS * 8 * 3 / 2 + 200;   // Half again as margin

  logic       hclk;
  logic       hresetn;
  logic       hsel;
  logic       hwrite;
  logic       hready;
  htrans_e    htrans;
  hsize_e     hsize;
  ahb_addr_t  haddr;
  ahb_data_t  hwdata;
  mem_data_t  fsmc_di;
  logic       word_1sthalf;
  logic       word_1sthalf_clr;
  logic       hreadyout_bank;
  logic       hreadyout;
  logic [1:0] hresp;
  ahb_data_t  hrdata;
  ctrl_regs_t ctrl_regs;
  logic       buf_we;
  logic       tx_byte;
  logic       tx_word;
  logic       ahb_access;
  bank_sel_t  fsmc_bank_sel;
  mem_addr_t  buf_adr;
  ahb_data_t  hwdata_r;

  // Reference state
  ahb_data_t   reg_model [NUM_CTRL_REGS];
  mem_data_t   half_model;
  logic [31:0] lfsr = LFSR_SEED;
  int          cycle_count = 0;

  // Data phase tracking for the compare process
  logic        dp_valid = 1'b0;
  logic        dp_write;
  ahb_addr_t   dp_addr;
  hsize_e      dp_size;
  logic        rep_pend = 1'b0;
  ahb_data_t   rep_exp;

  fsmc_ahb_slave #(.CTRL_PAGE(CTRL_PAGE), .BANK1_NIBBLE(BANK1_NIBBLE)) UUT (.*);

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;
  end

  // ------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------
  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Slot order BCR1-4, BTR1-4, BWTR1-4
  function automatic reg_word_idx_t reg_ofs(input int slot);
    if (slot < 4)
      return reg_word_idx_t'(BCR_BASE_OFS + 2 * slot);
    if (slot < 8)
      return reg_word_idx_t'(BTR_BASE_OFS + 2 * (slot - 4));
    return reg_word_idx_t'(BWTR_BASE_OFS + 2 * (slot - 8));
  endfunction

  function automatic int reg_slot(input reg_word_idx_t ofs);
    for (int i = 0; i < NUM_CTRL_REGS; i++) begin
      if (reg_ofs(i) == ofs)
        return i;
    end
    return -1;   // Dropped or unused offset
  endfunction

  function automatic ahb_data_t reg_read(input reg_word_idx_t ofs);
    int slot;
    slot = reg_slot(ofs);
    return (slot < 0) ? '0 : reg_model[slot];
  endfunction

  function automatic ahb_data_t lane_replicate(input ahb_data_t w, input logic [1:0] lane,
                                               input hsize_e size);
    case (size)
      HSIZE_BYTE: return {4{w[8*lane +: 8]}};
      HSIZE_HALF: return {2{w[16*lane[1] +: 16]}};
      default:    return w;
    endcase
  endfunction

  function automatic ahb_data_t read_assemble(input mem_data_t di, input mem_data_t half,
                                              input logic word);
    return word ? {di, half} : {di, di};
  endfunction

  function automatic bank_sel_t bank_decode(input ahb_addr_t addr);
    bank_sel_t sel;
    sel = '0;
    for (int i = 0; i < 4; i++) begin
      if (addr[31:28] == 4'(BANK1_NIBBLE + i))
        sel[i] = 1'b1;
    end
    return sel;
  endfunction

  function automatic ahb_addr_t ctrl_addr(input reg_word_idx_t ofs);
    return {CTRL_PAGE, 2'b00, ofs, 2'b00};
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_data(input string name, input ahb_data_t act, input ahb_data_t exp);
    if (act !== exp)
      fail_now($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_addr(input string name, input mem_addr_t act, input mem_addr_t exp);
    if (act !== exp)
      fail_now($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_bank(input string name, input bank_sel_t act, input bank_sel_t exp);
    if (act !== exp)
      fail_now($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
      fail_now($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  always @(posedge hclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_now($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // Outputs are checked mid-cycle, away from the driving edge
  always @(negedge hclk) begin
    if (hresetn) begin
      if (rep_pend) begin
        check_data("hwdata_r", hwdata_r, rep_exp);
        rep_pend = 1'b0;
      end
      if (dp_valid && bank_decode(dp_addr) != '0) begin
        check_bank("fsmc_bank_sel", fsmc_bank_sel, bank_decode(dp_addr));
        check_bit("hreadyout", hreadyout, hreadyout_bank);
        check_addr("buf_adr", buf_adr, dp_addr[27:0]);
        check_bit("buf_we", buf_we, dp_write);
        check_bit("tx_byte", tx_byte, dp_size == HSIZE_BYTE);
        check_bit("tx_word", tx_word, dp_size == HSIZE_WORD);
        if (!dp_write) begin
          check_data("hrdata", hrdata,
                     read_assemble(fsmc_di, half_model, dp_size == HSIZE_WORD));
        end else if (hready) begin
          rep_exp  = lane_replicate(hwdata, dp_addr[1:0], dp_size);
          rep_pend = 1'b1;   // Loaded on the closing edge
        end
      end else if (dp_valid) begin
        check_bank("fsmc_bank_sel", fsmc_bank_sel, '0);
        check_bit("hreadyout", hreadyout, 1'b1);
        if (!dp_write)
          check_data("hrdata", hrdata, reg_read(dp_addr[9:2]));
        else if (reg_slot(dp_addr[9:2]) >= 0)
          reg_model[reg_slot(dp_addr[9:2])] = hwdata;
      end else begin
        check_bank("fsmc_bank_sel", fsmc_bank_sel, '0);
        check_bit("hreadyout", hreadyout, 1'b1);
      end
      check_bit("ahb_access", ahb_access,
                hsel && htrans[1] && hready && (bank_decode(haddr) != '0));
      if (hready) begin   // Address phase accepted on the next edge
        dp_valid = hsel && htrans[1];
        dp_write = hwrite;
        dp_addr  = haddr;
        dp_size  = hsize;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  // Single NONSEQ transfer, then IDLE
  task automatic ahb_xfer(input ahb_addr_t addr, input logic wr, input hsize_e size,
                          input ahb_data_t wdata, input int stall);
    @(posedge hclk);
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    haddr  <= addr;
    hwrite <= wr;
    hsize  <= size;
    @(posedge hclk);   // Data phase
    hwdata <= wdata;
    if (stall > 0) begin
      hready         <= 1'b0;
      hreadyout_bank <= 1'b0;
      haddr          <= addr ^ 32'h1000_0000;   // Waiting transfer to a neighbour bank
      repeat (stall) @(posedge hclk);
      hready         <= 1'b1;
      hreadyout_bank <= 1'b1;
    end
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    @(negedge hclk);
    while (!hreadyout)
      @(negedge hclk);
    @(posedge hclk);   // End of data phase
  endtask

  // Latch or clear the first half of a word read
  task automatic set_first_half(input logic load, input mem_data_t lo, input mem_data_t hi);
    @(posedge hclk);
    if (load) begin
      word_1sthalf <= 1'b1;
      fsmc_di      <= lo;
    end else begin
      word_1sthalf_clr <= 1'b1;
    end
    @(posedge hclk);
    word_1sthalf     <= 1'b0;
    word_1sthalf_clr <= 1'b0;
    fsmc_di          <= hi;
    half_model = load ? lo : '0;
  endtask

  initial begin
    ahb_addr_t     addr;
    reg_word_idx_t ofs;
    hsize_e        size;
    logic [31:0]   r;
    hresetn          = 1'b0;
    hsel             = 1'b0;
    hwrite           = 1'b0;
    hready           = 1'b1;
    htrans           = HTRANS_IDLE;
    hsize            = HSIZE_WORD;
    haddr            = '0;
    hwdata           = '0;
    fsmc_di          = '0;
    word_1sthalf     = 1'b0;
    word_1sthalf_clr = 1'b0;
    hreadyout_bank   = 1'b1;
    half_model       = '0;
    for (int i = 0; i < NUM_CTRL_REGS; i++)
      reg_model[i] = (i == 0) ? BCR1_DEF : (i < 4) ? BCRX_DEF : (i < 8) ? BTR_DEF : BWTR_DEF;
    repeat (8) @(posedge hclk);
    hresetn <= 1'b1;

    // Defaults, then a dropped NAND offset
    for (int i = 0; i < NUM_CTRL_REGS; i++)
      ahb_xfer(ctrl_addr(reg_ofs(i)), 1'b0, HSIZE_WORD, '0, 0);
    ahb_xfer(ctrl_addr(8'h18), 1'b0, HSIZE_WORD, '0, 0);

    // Random control page writes with read back
    for (int n = 0; n < 80; n++) begin
      if (rand_bits(1) == 32'd1)
        ofs = reg_ofs(int'(rand_bits(4)) % NUM_CTRL_REGS);
      else
        ofs = reg_word_idx_t'(rand_bits(8));
      ahb_xfer(ctrl_addr(ofs), 1'b1, HSIZE_WORD, rand_bits(32), 0);
      ahb_xfer(ctrl_addr(ofs), 1'b0, HSIZE_WORD, '0, 0);
    end
    for (int i = 0; i < NUM_CTRL_REGS; i++)
      ahb_xfer(ctrl_addr(reg_ofs(i)), 1'b0, HSIZE_WORD, '0, 0);

    // Every bank, size and lane
    for (int b = 0; b < 4; b++) begin
      for (int k = 0; k < 7; k++) begin
        r    = rand_bits(26);
        size = (k < 4) ? HSIZE_BYTE : (k < 6) ? HSIZE_HALF : HSIZE_WORD;
        addr = {4'(BANK1_NIBBLE + b), r[25:0], (k < 4) ? 2'(k) : (k == 5) ? 2'd2 : 2'd0};
        ahb_xfer(addr, 1'b1, size, rand_bits(32), 0);
        ahb_xfer(addr, 1'b0, size, '0, 0);
      end
    end

    // Bank reads with first-half capture, clear and wait states
    for (int n = 0; n < 100; n++) begin
      set_first_half(rand_bits(2) != 32'd0, mem_data_t'(rand_bits(16)),
                     mem_data_t'(rand_bits(16)));
      r    = rand_bits(32);
      size = hsize_e'({1'b0, r[1:0] % 2'd3});
      addr = {4'(BANK1_NIBBLE + r[3:2]), r[29:4], 2'b00};
      if (size == HSIZE_BYTE)
        addr[1:0] = r[31:30];
      else if (size == HSIZE_HALF)
        addr[1] = r[31];
      ahb_xfer(addr, 1'b0, size, '0, int'(rand_bits(2)));
    end

    repeat (2) @(negedge hclk);
    for (int i = 0; i < NUM_CTRL_REGS; i++)
      check_data("ctrl_regs", ctrl_regs[i], reg_model[i]);
    if (UUT.u_checker.fail_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- common/fsmc_pkg.sv
package fsmc_pkg;

  // ------------------------------------------------------------
  // Bus and memory widths
  // ------------------------------------------------------------
  typedef logic [31:0] ahb_addr_t;
  typedef logic [31:0] ahb_data_t;
  typedef logic [15:0] mem_data_t;   // External memory data bus
  typedef logic [27:0] mem_addr_t;   // Byte address inside a bank
  typedef logic [3:0]  bank_sel_t;   // One-hot, bit 0 is bank 1

  // ------------------------------------------------------------
  // AHB encodings
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  localparam logic [1:0] hresp_okay = 2'b00;

  // ------------------------------------------------------------
  // Control page registers
  // ------------------------------------------------------------
  localparam int NUM_CTRL_REGS = 12;

  // BCR1-4, then BTR1-4, then BWTR1-4
  typedef logic [NUM_CTRL_REGS-1:0][31:0] ctrl_regs_t;

  // Word offset, haddr[9:2]
  typedef logic [7:0] reg_word_idx_t;

  // BCRn and BTRn interleave, BWTRn every other word from 41h
  localparam reg_word_idx_t BCR_BASE_OFS  = 8'h00;
  localparam reg_word_idx_t BTR_BASE_OFS  = 8'h01;
  localparam reg_word_idx_t BWTR_BASE_OFS = 8'h41;

  // Reset values
  localparam ahb_data_t BCR1_DEF = 32'h0000_30DB;
  localparam ahb_data_t BCRX_DEF = 32'h0000_30D2;   // Banks 2 to 4
  localparam ahb_data_t BTR_DEF  = 32'h0FFF_FFFF;
  localparam ahb_data_t BWTR_DEF = 32'h0FFF_FFFF;

endpackage

//--- design/fsmc_ahb_slave.sv
`timescale 1ns/1ps

module fsmc_ahb_slave import fsmc_pkg::*; #(
  parameter logic [19:0] CTRL_PAGE    = 20'hA_0000,
  parameter logic [3:0]  BANK1_NIBBLE = 4'h6
) (
  input  logic       hclk,
  input  logic       hresetn,
  input  logic       hsel,
  input  logic       hwrite,
  input  logic       hready,
  input  htrans_e    htrans,
  input  hsize_e     hsize,
  input  ahb_addr_t  haddr,
  input  ahb_data_t  hwdata,
  input  mem_data_t  fsmc_di,
  input  logic       word_1sthalf,
  input  logic       word_1sthalf_clr,
  input  logic       hreadyout_bank,
  output logic       hreadyout,
  output logic [1:0] hresp,
  output ahb_data_t  hrdata,
  output ctrl_regs_t ctrl_regs,
  output logic       buf_we,
  output logic       tx_byte,
  output logic       tx_word,
  output logic       ahb_access,
  output bank_sel_t  fsmc_bank_sel,
  output mem_addr_t  buf_adr,
  output ahb_data_t  hwdata_r
);

  bank_sel_t     bank_hit;
  logic          reg_wr;
  reg_word_idx_t wr_idx;
  reg_word_idx_t rd_idx;
  ahb_data_t     ctrl_rdata;
  ahb_data_t     mem_rdata;

  // No error responses from either target
  assign hresp = hresp_okay;

  // ------------------------------------------------------------
  // Bus side and control page
  // ------------------------------------------------------------
  ahb_bus_port #(.CTRL_PAGE(CTRL_PAGE), .BANK1_NIBBLE(BANK1_NIBBLE)) u_bus_port (
    .hclk, .hresetn, .hsel, .hwrite, .hready, .htrans, .haddr,
    .ctrl_rdata, .mem_rdata, .hreadyout_bank,
    .bank_hit, .fsmc_bank_sel, .reg_wr, .wr_idx, .rd_idx, .hrdata, .hreadyout
  );

  fsmc_ctrl_regs u_ctrl_regs (
    .hclk, .hresetn, .reg_wr, .wr_idx, .rd_idx, .hwdata,
    .ctrl_regs, .ctrl_rdata
  );

  // ------------------------------------------------------------
  // Memory side
  // ------------------------------------------------------------
  mem_access_ctrl u_access_ctrl (
    .hclk, .hresetn, .hsel, .hwrite, .hready, .htrans, .hsize, .haddr, .hwdata,
    .bank_hit, .ahb_access, .buf_we, .tx_byte, .tx_word, .buf_adr, .hwdata_r
  );

  mem_read_assembler u_read_asm (
    .hclk, .hresetn, .fsmc_di, .word_1sthalf, .word_1sthalf_clr, .tx_word,
    .mem_rdata
  );

endmodule

//--- fsmc_ahb_slave.f
common/fsmc_pkg.sv
ahb/ahb_bus_port.sv
regs/fsmc_ctrl_regs.sv
mem/mem_access_ctrl.sv
mem/mem_read_assembler.sv
design/fsmc_ahb_slave.sv
bench/fsmc_ahb_slave_checker.sv
bench/fsmc_ahb_slave_tb.sv

//--- mem/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl import fsmc_pkg::*; (
  input  logic      hclk,
  input  logic      hresetn,
  input  logic      hsel,
  input  logic      hwrite,
  input  logic      hready,
  input  htrans_e   htrans,
  input  hsize_e    hsize,
  input  ahb_addr_t haddr,
  input  ahb_data_t hwdata,
  input  bank_sel_t bank_hit,
  output logic      ahb_access,
  output logic      buf_we,
  output logic      tx_byte,
  output logic      tx_word,
  output mem_addr_t buf_adr,
  output ahb_data_t hwdata_r
);

  logic       size_byte;
  logic       size_half;
  logic       size_word;
  logic       ahb_write_r;
  logic [3:0] byte_lane;
  logic [1:0] half_lane;
  logic [3:0] byte_lane_q;
  logic [1:0] half_lane_q;
  ahb_data_t  wdata_rep;

  // Active transfer to any bank, address phase only
  assign ahb_access = htrans[1] & (|bank_hit) & hready;

  // ------------------------------------------------------------
  // Size and lane decode
  // ------------------------------------------------------------
  assign size_byte = ~hsize[1] & ~hsize[0];
  assign size_half = ~hsize[1] &  hsize[0];
  assign size_word =  hsize[1];

  for (genvar k = 0; k < 4; k++) begin : g_byte_lane
    assign byte_lane[k] = size_byte && (haddr[1:0] == 2'(k));
  end
  assign half_lane = {size_half & haddr[1], size_half & ~haddr[1]};

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      buf_we  <= 1'b0;
      tx_byte <= 1'b0;
      tx_word <= 1'b0;
    end else if (ahb_access) begin
      buf_we  <= hwrite;
      tx_byte <= size_byte;
      tx_word <= size_word;
    end
  end

  always_ff @(posedge hclk) begin
    if (ahb_access)
      buf_adr <= haddr[27:0];
  end

  // ------------------------------------------------------------
  // Write data replication
  // ------------------------------------------------------------
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      ahb_write_r <= 1'b0;
      byte_lane_q <= '0;
      half_lane_q <= '0;
    end else begin
      if (hsel)
        ahb_write_r <= ahb_access & hwrite;
      byte_lane_q <= byte_lane;   // Lanes for the following data phase
      half_lane_q <= half_lane;
    end
  end

  always_comb begin
    wdata_rep = hwdata;   // Word access
    if (half_lane_q[0])
      wdata_rep = {2{hwdata[15:0]}};
    if (half_lane_q[1])
      wdata_rep = {2{hwdata[31:16]}};
    for (int k = 0; k < 4; k++) begin
      if (byte_lane_q[k])
        wdata_rep = {4{hwdata[8*k +: 8]}};
    end
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      hwdata_r <= '0;
    else if (ahb_write_r)
      hwdata_r <= wdata_rep;
  end

endmodule

//--- mem/mem_read_assembler.sv
`timescale 1ns/1ps

module mem_read_assembler import fsmc_pkg::*; (
  input  logic      hclk,
  input  logic      hresetn,
  input  mem_data_t fsmc_di,
  input  logic      word_1sthalf,
  input  logic      word_1sthalf_clr,
  input  logic      tx_word,
  output ahb_data_t mem_rdata
);

  logic      word_1sthalf_q;
  logic      first_half_rise;
  mem_data_t first_half;

  // ------------------------------------------------------------
  // First half capture
  // ------------------------------------------------------------
  assign first_half_rise = word_1sthalf & ~word_1sthalf_q;

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      word_1sthalf_q <= 1'b0;
    else
      word_1sthalf_q <= word_1sthalf;
  end

  // A rise in the same cycle as a clear wins
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      first_half <= '0;
    else if (first_half_rise)
      first_half <= fsmc_di;
    else if (word_1sthalf_clr)
      first_half <= '0;
  end

  // Lower half from the earlier beat on word reads
  assign mem_rdata = tx_word ? {fsmc_di, first_half} : {fsmc_di, fsmc_di};

endmodule

//--- regs/fsmc_ctrl_regs.sv
`timescale 1ns/1ps

module fsmc_ctrl_regs import fsmc_pkg::*; (
  input  logic          hclk,
  input  logic          hresetn,
  input  logic          reg_wr,
  input  reg_word_idx_t wr_idx,
  input  reg_word_idx_t rd_idx,
  input  ahb_data_t     hwdata,
  output ctrl_regs_t    ctrl_regs,
  output ahb_data_t     ctrl_rdata
);

  // One BCR, BTR and BWTR per bank
  localparam int NUM_BANKS = NUM_CTRL_REGS / 3;

  // Index 0 sits in the low word
  localparam ctrl_regs_t REG_DEFS = {
    BWTR_DEF, BWTR_DEF, BWTR_DEF, BWTR_DEF,
    BTR_DEF,  BTR_DEF,  BTR_DEF,  BTR_DEF,
    BCRX_DEF, BCRX_DEF, BCRX_DEF, BCR1_DEF
  };

  logic [NUM_CTRL_REGS-1:0] wr_dec;
  logic [NUM_CTRL_REGS-1:0] rd_dec;

  // ------------------------------------------------------------
  // Offset decode
  // ------------------------------------------------------------
  // One-hot slot for a word offset, zero when unknown
  function automatic logic [NUM_CTRL_REGS-1:0] decode_ofs(input reg_word_idx_t ofs);
    logic [NUM_CTRL_REGS-1:0] dec;
    dec = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      dec[i]               = (ofs == reg_word_idx_t'(BCR_BASE_OFS  + 2 * i));
      dec[NUM_BANKS + i]   = (ofs == reg_word_idx_t'(BTR_BASE_OFS  + 2 * i));
      dec[2*NUM_BANKS + i] = (ofs == reg_word_idx_t'(BWTR_BASE_OFS + 2 * i));
    end
    return dec;
  endfunction

  assign wr_dec = decode_ofs(wr_idx);
  assign rd_dec = decode_ofs(rd_idx);

  // ------------------------------------------------------------
  // Register storage
  // ------------------------------------------------------------
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      ctrl_regs <= REG_DEFS;
    end else if (reg_wr) begin
      for (int i = 0; i < NUM_CTRL_REGS; i++) begin
        if (wr_dec[i])
          ctrl_regs[i] <= hwdata;   // Unknown offsets match no slot
      end
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  // At most one slot is decoded, so an OR tree is enough
  always_comb begin
    ctrl_rdata = '0;
    for (int i = 0; i < NUM_CTRL_REGS; i++) begin
      if (rd_dec[i])
        ctrl_rdata = ctrl_rdata | ctrl_regs[i];
    end
  end

endmodule
